// ==== ucpd_pkg.sv ====
`default_nettype none

package ucpd_pkg;

  // --------------------------------------------------
  // widths
  // --------------------------------------------------

  // run-length counters and the half-UI threshold
  parameter int UI_CNT_W = 11;

  // run length or threshold, in ucpd_clk cycles
  typedef logic [UI_CNT_W-1:0] ui_cnt_t;

  // accumulator for threshold averaging
  typedef logic [UI_CNT_W:0] ui_sum_t;

  // --------------------------------------------------
  // filter configuration
  // --------------------------------------------------

  // bit 1 two-sample match when set, three-sample when clear
  // bit 0 filter bypass
  typedef logic [1:0] filt_cfg_t;

  localparam int FILT_BYP_BIT = 0;
  localparam int FILT_2N3_BIT = 1;

  // --------------------------------------------------
  // trainer
  // --------------------------------------------------

  // eight thresholds averaged per lock
  localparam int AVG_SHIFT = 3;

  typedef enum logic [1:0] {
    TRN_IDLE    = 2'd0,
    TRN_MEASURE = 2'd1,
    TRN_AVERAGE = 2'd2,
    TRN_LOCKED  = 2'd3
  } trn_state_t;

endpackage

`default_nettype wire

// ==== ucpd_cc_filter.sv ====
`timescale 1ns/1ns
`default_nettype none

module ucpd_cc_filter (
  input  wire                 ucpd_clk,
  input  wire                 ic_rst_n,
  input  wire                 cc_in,
  input  ucpd_pkg::filt_cfg_t filt_cfg,
  output logic                cc_filt,
  output logic                cc_edge
);

  import ucpd_pkg::*;

  // two-flop synchronizer
  logic sync_q1;
  logic sync_q2;
  // history of synchronized samples
  logic hist_q0;
  logic hist_q1;
  // filtered level and next value
  logic filt_q;
  logic filt_nxt;

  // --------------------------------------------------
  // synchronizer and sample history
  // --------------------------------------------------
  always_ff @(posedge ucpd_clk or negedge ic_rst_n) begin
    if (!ic_rst_n) begin
      sync_q1 <= 1'b0;
      sync_q2 <= 1'b0;
      hist_q0 <= 1'b0;
      hist_q1 <= 1'b0;
    end else begin
      sync_q1 <= cc_in;
      sync_q2 <= sync_q1;
      hist_q0 <= sync_q2;
      hist_q1 <= hist_q0;
    end
  end

  // --------------------------------------------------
  // glitch filter
  // --------------------------------------------------
  always_comb begin
    // hold level unless samples agree
    filt_nxt = filt_q;
    if (filt_cfg[FILT_BYP_BIT]) begin
      filt_nxt = sync_q2;
    end else if (filt_cfg[FILT_2N3_BIT]) begin
      // last two samples match
      if (sync_q2 == hist_q0) begin
        filt_nxt = sync_q2;
      end
    end else begin
      // last three samples match
      if ((sync_q2 == hist_q0) && (hist_q0 == hist_q1)) begin
        filt_nxt = sync_q2;
      end
    end
  end

  // level and edge strobe leave on the same cycle
  always_ff @(posedge ucpd_clk or negedge ic_rst_n) begin
    if (!ic_rst_n) begin
      filt_q  <= 1'b0;
      cc_edge <= 1'b0;
    end else begin
      filt_q  <= filt_nxt;
      cc_edge <= filt_nxt ^ filt_q;
    end
  end

  assign cc_filt = filt_q;

endmodule

`default_nettype wire

// ==== ucpd_ui_trainer.sv ====
`timescale 1ns/1ns
`default_nettype none

module ucpd_ui_trainer #(
  parameter int UI_CNT_W = ucpd_pkg::UI_CNT_W
) (
  input  wire                 ucpd_clk,
  input  wire                 ic_rst_n,
  input  wire                 cc_filt,
  input  wire                 cc_edge,
  input  wire                 rx_pre_en,
  input  wire                 rx_stop,
  output logic [UI_CNT_W-1:0] ui_thresh,
  output logic                locked
);

  import ucpd_pkg::*;

  trn_state_t state;

  // per-level run counters
  logic [UI_CNT_W-1:0] hi_cnt;
  logic [UI_CNT_W-1:0] lo_cnt;
  logic [UI_CNT_W-1:0] run_len;
  // stored runs A and B, C is the run ending now
  logic [UI_CNT_W-1:0] run_a;
  logic [UI_CNT_W-1:0] run_b;
  logic [1:0]          run_idx;
  logic                skip_run;
  // triple evaluation
  logic [UI_CNT_W+1:0] trip_sum;
  logic [UI_CNT_W+3:0] trip_x3;
  logic [UI_CNT_W-1:0] trip_th;
  logic                trip_ok;
  // averaging
  logic [UI_CNT_W:0]   acc_sum;
  logic [UI_CNT_W:0]   acc_nxt;
  logic [AVG_SHIFT-1:0] avg_cnt;

  // --------------------------------------------------
  // run length measurement
  // --------------------------------------------------
  // each counter runs while its level is present, saturating
  always_ff @(posedge ucpd_clk or negedge ic_rst_n) begin
    if (!ic_rst_n) begin
      hi_cnt <= '0;
      lo_cnt <= '0;
    end else if (cc_filt) begin
      lo_cnt <= '0;
      if (~&hi_cnt) begin
        hi_cnt <= hi_cnt + 1'b1;
      end
    end else begin
      hi_cnt <= '0;
      if (~&lo_cnt) begin
        lo_cnt <= lo_cnt + 1'b1;
      end
    end
  end

  // on an edge the level is already new, the run just ended is the other one
  assign run_len = cc_filt ? lo_cnt : hi_cnt;

  // --------------------------------------------------
  // triple check and 3/8 threshold
  // --------------------------------------------------
  // full UI plus two halves, long run first or last
  assign trip_ok = ((run_len > run_a) && (run_len > run_b)) ||
                   ((run_a > run_b) && (run_a > run_len));

  // a+b+c is two UI, 3/8 of it is 3/4 UI
  assign trip_sum = run_a + run_b + run_len;
  assign trip_x3  = trip_sum + (trip_sum << 1);
  assign trip_th  = trip_x3[UI_CNT_W+2:3];
  assign acc_nxt  = acc_sum + trip_th;

  // --------------------------------------------------
  // trainer FSM
  // --------------------------------------------------
  always_ff @(posedge ucpd_clk or negedge ic_rst_n) begin
    if (!ic_rst_n) begin
      state     <= TRN_IDLE;
      skip_run  <= 1'b0;
      run_idx   <= 2'd0;
      run_a     <= '0;
      run_b     <= '0;
      acc_sum   <= '0;
      avg_cnt   <= '0;
      ui_thresh <= '0;
      locked    <= 1'b0;
    end else begin
      case (state)
        TRN_IDLE: begin
          if (rx_pre_en && !rx_stop) begin
            // first run is partial, throw it away
            state    <= TRN_MEASURE;
            skip_run <= 1'b1;
            run_idx  <= 2'd0;
            acc_sum  <= '0;
            avg_cnt  <= '0;
          end
        end
        TRN_MEASURE, TRN_AVERAGE: begin
          if (!rx_pre_en || rx_stop) begin
            state <= TRN_IDLE;
          end else if (cc_edge) begin
            if (skip_run) begin
              skip_run <= 1'b0;
            end else if (run_idx == 2'd0) begin
              run_a   <= run_len;
              run_idx <= 2'd1;
            end else if (run_idx == 2'd1) begin
              run_b   <= run_len;
              run_idx <= 2'd2;
            end else begin
              run_idx <= 2'd0;
              if (trip_ok) begin
                acc_sum <= acc_nxt;
                avg_cnt <= avg_cnt + 1'b1;
                if (&avg_cnt) begin
                  // eighth threshold, average and lock
                  state     <= TRN_LOCKED;
                  ui_thresh <= UI_CNT_W'(acc_nxt >> AVG_SHIFT);
                  locked    <= 1'b1;
                end else begin
                  state <= TRN_AVERAGE;
                end
              end else begin
                // long run in the middle, drop and shift phase by one run
                skip_run <= 1'b1;
                state    <= TRN_MEASURE;
              end
            end
          end
        end
        TRN_LOCKED: begin
          if (rx_stop) begin
            state     <= TRN_IDLE;
            ui_thresh <= '0;
            locked    <= 1'b0;
          end
        end
        default: begin
          state <= TRN_IDLE;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== ucpd_bmc_decoder.sv ====
`timescale 1ns/1ns
`default_nettype none

module ucpd_bmc_decoder #(
  parameter int UI_CNT_W = ucpd_pkg::UI_CNT_W
) (
  input  wire                ucpd_clk,
  input  wire                ic_rst_n,
  input  wire                cc_edge,
  input  wire [UI_CNT_W-1:0] ui_thresh,
  input  wire                locked,
  input  wire                phy_rx_en,
  input  wire                rx_stop,
  output logic               rx_bit,
  output logic               rx_bit_vld,
  output logic               receive_en
);

  // clocks since the last edge
  logic [UI_CNT_W-1:0] run_cnt;
  // first half of a 1 bit seen
  logic                half_pend;
  logic                run_long;
  logic                emit_zero;
  logic                emit_one;

  // --------------------------------------------------
  // receive enable
  // --------------------------------------------------
  always_ff @(posedge ucpd_clk or negedge ic_rst_n) begin
    if (!ic_rst_n) begin
      receive_en <= 1'b0;
    end else if (rx_stop) begin
      receive_en <= 1'b0;
    end else if (locked && phy_rx_en) begin
      receive_en <= 1'b1;
    end
  end

  // --------------------------------------------------
  // run counter
  // --------------------------------------------------
  // loads 1 on an edge so its value is the run length at the next edge
  always_ff @(posedge ucpd_clk or negedge ic_rst_n) begin
    if (!ic_rst_n) begin
      run_cnt <= '0;
    end else if (rx_stop) begin
      run_cnt <= '0;
    end else if (cc_edge) begin
      run_cnt <= UI_CNT_W'(1);
    end else if (~&run_cnt) begin
      run_cnt <= run_cnt + 1'b1;
    end
  end

  // --------------------------------------------------
  // bit decision
  // --------------------------------------------------
  // longer than 3/4 UI is a full UI
  assign run_long  = run_cnt > ui_thresh;
  assign emit_zero = receive_en && cc_edge && run_long;
  assign emit_one  = receive_en && cc_edge && !run_long && half_pend;

  always_ff @(posedge ucpd_clk or negedge ic_rst_n) begin
    if (!ic_rst_n) begin
      half_pend  <= 1'b0;
      rx_bit_vld <= 1'b0;
    end else begin
      rx_bit_vld <= emit_zero || emit_one;
      if (rx_stop || !receive_en) begin
        half_pend <= 1'b0;
      end else if (cc_edge) begin
        // a long run also resyncs a stray half
        half_pend <= !run_long && !half_pend;
      end
    end
  end

  // bit value, qualified by rx_bit_vld
  always_ff @(posedge ucpd_clk) begin
    if (emit_zero) begin
      rx_bit <= 1'b0;
    end else if (emit_one) begin
      rx_bit <= 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== ucpd_bmc_encoder.sv ====
`timescale 1ns/1ns
`default_nettype none

module ucpd_bmc_encoder (
  input  wire  ucpd_clk,
  input  wire  ic_rst_n,
  input  wire  bmc_en,
  input  wire  tx_bit,
  input  wire  bit_strb,
  input  wire  hbit_strb,
  output logic cc_out
);

  // --------------------------------------------------
  // BMC encode
  // --------------------------------------------------
  // transition at every bit boundary
  // extra mid-bit transition for a 1

  logic tx_toggle;

  assign tx_toggle = bit_strb || (hbit_strb && tx_bit);

  always_ff @(posedge ucpd_clk or negedge ic_rst_n) begin
    if (!ic_rst_n) begin
      cc_out <= 1'b0;
    end else if (!bmc_en) begin
      // line parked low when idle
      cc_out <= 1'b0;
    end else if (tx_toggle) begin
      cc_out <= ~cc_out;
    end
  end

endmodule

`default_nettype wire

// ==== ucpd_bmc_phy.sv ====
`timescale 1ns/1ns
`default_nettype none

module ucpd_bmc_phy #(
  parameter int UI_CNT_W = ucpd_pkg::UI_CNT_W
) (
  input  wire                 ucpd_clk,
  input  wire                 ic_rst_n,
  input  wire                 cc_in,
  input  ucpd_pkg::filt_cfg_t filt_cfg,
  input  wire                 rx_pre_en,
  input  wire                 phy_rx_en,
  input  wire                 rx_stop,
  input  wire                 bmc_en,
  input  wire                 tx_bit,
  input  wire                 bit_strb,
  input  wire                 hbit_strb,
  output logic                cc_out,
  output logic                rx_bit,
  output logic                rx_bit_vld,
  output logic                receive_en,
  output logic [UI_CNT_W-1:0] ui_thresh,
  output logic                locked
);

  // filtered CC level and its edge strobe
  logic cc_filt;
  logic cc_edge;

  // --------------------------------------------------
  // receive path
  // --------------------------------------------------
  ucpd_cc_filter u_cc_filter (
    .ucpd_clk (ucpd_clk),
    .ic_rst_n (ic_rst_n),
    .cc_in    (cc_in),
    .filt_cfg (filt_cfg),
    .cc_filt  (cc_filt),
    .cc_edge  (cc_edge)
  );

  // preamble training, rx_stop also drops lock
  ucpd_ui_trainer #(
    .UI_CNT_W (UI_CNT_W)
  ) u_ui_trainer (
    .ucpd_clk  (ucpd_clk),
    .ic_rst_n  (ic_rst_n),
    .cc_filt   (cc_filt),
    .cc_edge   (cc_edge),
    .rx_pre_en (rx_pre_en),
    .rx_stop   (rx_stop),
    .ui_thresh (ui_thresh),
    .locked    (locked)
  );

  ucpd_bmc_decoder #(
    .UI_CNT_W (UI_CNT_W)
  ) u_bmc_decoder (
    .ucpd_clk   (ucpd_clk),
    .ic_rst_n   (ic_rst_n),
    .cc_edge    (cc_edge),
    .ui_thresh  (ui_thresh),
    .locked     (locked),
    .phy_rx_en  (phy_rx_en),
    .rx_stop    (rx_stop),
    .rx_bit     (rx_bit),
    .rx_bit_vld (rx_bit_vld),
    .receive_en (receive_en)
  );

  // --------------------------------------------------
  // transmit path
  // --------------------------------------------------
  ucpd_bmc_encoder u_bmc_encoder (
    .ucpd_clk  (ucpd_clk),
    .ic_rst_n  (ic_rst_n),
    .bmc_en    (bmc_en),
    .tx_bit    (tx_bit),
    .bit_strb  (bit_strb),
    .hbit_strb (hbit_strb),
    .cc_out    (cc_out)
  );

endmodule

`default_nettype wire

// ==== tb_ucpd_bmc_phy.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_ucpd_bmc_phy;

  import ucpd_pkg::*;

  localparam int NUM_ROWS = 5;
  localparam int PRE_BITS = 64;
  localparam int PL_BITS  = 16;
  localparam int TX_UI    = 20;
  localparam int LOCK_TMO = 20000;
  localparam int VLD_TMO  = 2000;

  logic       ucpd_clk;
  logic       ic_rst_n;
  logic       cc_in;
  filt_cfg_t  filt_cfg;
  logic       rx_pre_en;
  logic       phy_rx_en;
  logic       rx_stop;
  logic       bmc_en;
  logic       tx_bit;
  logic       bit_strb;
  logic       hbit_strb;
  logic       cc_out;
  logic       rx_bit;
  logic       rx_bit_vld;
  logic       receive_en;
  ui_cnt_t    ui_thresh;
  logic       locked;

  // --------------------------------------------------
  // stimulus table with one row per frame
  // --------------------------------------------------
  // one entry per row in each column
  int          row_ui     [NUM_ROWS] = '{40, 64, 100, 64, 40};
  filt_cfg_t   row_cfg    [NUM_ROWS] = '{2'b01, 2'b10, 2'b00, 2'b00, 2'b10};
  logic [15:0] row_pl     [NUM_ROWS] = '{16'ha5c3, 16'h0000, 16'h3c96, 16'h0000, 16'hf00f};
  logic        row_rand   [NUM_ROWS] = '{1'b0, 1'b1, 1'b0, 1'b1, 1'b0};
  logic        row_glitch [NUM_ROWS] = '{1'b0, 1'b0, 1'b1, 1'b1, 1'b0};
  // expected threshold of 3/4 UI
  int          row_th     [NUM_ROWS] = '{30, 48, 75, 48, 30};

  integer      seed;
  // BMC line level before glitches
  logic        cc_lvl;
  logic [15:0] exp_payload;
  logic        rx_window = 1'b0;
  logic        hung;
  int          vld_total = 0;
  int          vld_base = 0;
  int          rx_idx;
  int          err_val;
  int          err_other;
  int          mon_err_val = 0;
  int          mon_err_other = 0;

  ucpd_bmc_phy #(
    .UI_CNT_W (UI_CNT_W)
  ) dut_i (
    .ucpd_clk   (ucpd_clk),
    .ic_rst_n   (ic_rst_n),
    .cc_in      (cc_in),
    .filt_cfg   (filt_cfg),
    .rx_pre_en  (rx_pre_en),
    .phy_rx_en  (phy_rx_en),
    .rx_stop    (rx_stop),
    .bmc_en     (bmc_en),
    .tx_bit     (tx_bit),
    .bit_strb   (bit_strb),
    .hbit_strb  (hbit_strb),
    .cc_out     (cc_out),
    .rx_bit     (rx_bit),
    .rx_bit_vld (rx_bit_vld),
    .receive_en (receive_en),
    .ui_thresh  (ui_thresh),
    .locked     (locked)
  );

  initial begin
    ucpd_clk = 1'b0;
    forever #5 ucpd_clk = ~ucpd_clk;
  end

  // --------------------------------------------------
  // decoded bit monitor
  // --------------------------------------------------
  // pulses only allowed inside the payload window and in payload order
  always @(negedge ucpd_clk) begin
    if (ic_rst_n && rx_bit_vld) begin
      rx_idx = vld_total - vld_base;
      assert (rx_window && rx_idx < PL_BITS) else begin
        mon_err_other++;
        $display("unexpected rx_bit_vld pulse at %0t ns", $time);
      end
      if (rx_window && rx_idx < PL_BITS) begin
        assert (rx_bit == exp_payload[rx_idx]) else begin
          mon_err_val++;
          $display("ERR rx_bit: got 0x%0h exp 0x%0h at payload bit %0d",
                   rx_bit, exp_payload[rx_idx], rx_idx);
        end
      end
      vld_total++;
    end
  end

  // one BMC bit with an edge at the start and an extra mid edge for a 1
  // optional one-cycle inverted pulse at 1/4 UI
  task automatic send_bit(input logic b, input int ui, input logic glitch,
                          input logic open_rx);
    int c;
    for (c = 0; c < ui; c++) begin
      if (c == 0 || (b && c == ui / 2)) begin
        cc_lvl = ~cc_lvl;
      end
      cc_in = cc_lvl;
      if (glitch && c == ui / 4) begin
        cc_in = ~cc_lvl;
      end
      // start edge of bit 0 already through the filter
      if (open_rx && c == 8) begin
        phy_rx_en = 1'b1;
      end
      @(negedge ucpd_clk);
    end
  endtask

  task automatic run_row(input int r);
    int          ui;
    int          i;
    int          t;
    logic [15:0] pl;
    ui = row_ui[r];
    pl = row_rand[r] ? 16'($random(seed)) : row_pl[r];
    filt_cfg = row_cfg[r];
    rx_pre_en = 1'b1;
    repeat (4) @(negedge ucpd_clk);
    // alternating preamble starting with 0
    for (i = 0; i < PRE_BITS; i++) begin
      send_bit(i[0], ui, 1'b0, 1'b0);
    end
    t = 0;
    while (!locked && t < LOCK_TMO) begin
      @(negedge ucpd_clk);
      t++;
    end
    if (!locked) begin
      $display("timeout: trainer never locked in row %0d", r);
      err_other++;
      hung = 1'b1;
      return;
    end
    assert (ui_thresh > ui_cnt_t'(ui / 2) && ui_thresh < ui_cnt_t'(ui)) else begin
      err_val++;
      $display("ERR ui_thresh: got 0x%0h exp between 0x%0h and 0x%0h",
               ui_thresh, ui / 2, ui);
    end
    assert (int'(ui_thresh) >= row_th[r] - 2 && int'(ui_thresh) <= row_th[r] + 2) else begin
      err_val++;
      $display("ERR ui_thresh: got 0x%0h exp 0x%0h", ui_thresh, row_th[r]);
    end
    rx_pre_en = 1'b0;
    exp_payload = pl;
    vld_base = vld_total;
    rx_window = 1'b1;
    // payload goes LSB first and a trailing edge closes bit 15
    for (i = 0; i < PL_BITS; i++) begin
      send_bit(pl[i], ui, row_glitch[r], i == 0);
    end
    send_bit(1'b0, ui, 1'b0, 1'b0);
    t = 0;
    while (vld_total - vld_base < PL_BITS && t < VLD_TMO) begin
      @(negedge ucpd_clk);
      t++;
    end
    if (vld_total - vld_base < PL_BITS) begin
      $display("timeout: only %0d of %0d bits decoded in row %0d",
               vld_total - vld_base, PL_BITS, r);
      err_other++;
      hung = 1'b1;
      return;
    end
    rx_window = 1'b0;
    // stop pulse drops receive and lock
    rx_stop = 1'b1;
    @(negedge ucpd_clk);
    rx_stop = 1'b0;
    @(negedge ucpd_clk);
    assert (!receive_en) else begin
      err_val++;
      $display("ERR receive_en: got 0x%0h exp 0x0 after rx_stop", receive_en);
    end
    assert (!locked) else begin
      err_val++;
      $display("ERR locked: got 0x%0h exp 0x0 after rx_stop", locked);
    end
    // phy_rx_en stays high and receive must stay off without lock
    // more edges while the monitor flags any pulse
    for (i = 0; i < 8; i++) begin
      send_bit(1'($random(seed)), ui, 1'b0, 1'b0);
    end
    repeat (8) @(negedge ucpd_clk);
    assert (!receive_en) else begin
      err_val++;
      $display("ERR receive_en: got 0x%0h exp 0x0 after stop", receive_en);
    end
    phy_rx_en = 1'b0;
  endtask

  // count cc_out changes over one TX bit
  task automatic tx_one_bit(input logic b, output int toggles);
    int   c;
    logic prev;
    toggles = 0;
    prev = cc_out;
    tx_bit = b;
    for (c = 0; c < TX_UI; c++) begin
      bit_strb = (c == 0);
      hbit_strb = (c == TX_UI / 2);
      @(negedge ucpd_clk);
      if (cc_out != prev) begin
        toggles++;
      end
      prev = cc_out;
    end
    bit_strb = 1'b0;
    hbit_strb = 1'b0;
  endtask

  task automatic check_encoder();
    int   i;
    int   tg;
    logic b;
    // --------------------------------------------------
    // encoder disabled with the line parked low
    // --------------------------------------------------
    bmc_en = 1'b0;
    for (i = 0; i < 4; i++) begin
      tx_one_bit(i[0], tg);
      assert (tg == 0 && cc_out == 1'b0) else begin
        err_val++;
        $display("ERR cc_out: got 0x%0h exp 0x0 with %0d toggles, bmc_en low", cc_out, tg);
      end
    end
    bmc_en = 1'b1;
    @(negedge ucpd_clk);
    for (i = 0; i < PL_BITS; i++) begin
      b = 1'($random(seed));
      tx_one_bit(b, tg);
      assert (tg == (b ? 2 : 1)) else begin
        err_val++;
        $display("ERR cc_out toggles: got 0x%0h exp 0x%0h for tx_bit 0x%0h",
                 tg, b ? 2 : 1, b);
      end
    end
    bmc_en = 1'b0;
    repeat (2) @(negedge ucpd_clk);
    assert (cc_out == 1'b0) else begin
      err_val++;
      $display("ERR cc_out: got 0x%0h exp 0x0 after bmc_en low", cc_out);
    end
  endtask

  initial begin
    int r;
    int total;
    seed = 32'h6a2b;
    err_val = 0;
    err_other = 0;
    hung = 1'b0;
    cc_lvl = 1'b0;
    exp_payload = '0;
    ic_rst_n = 1'b0;
    cc_in = 1'b0;
    filt_cfg = 2'b01;
    rx_pre_en = 1'b0;
    phy_rx_en = 1'b0;
    rx_stop = 1'b0;
    bmc_en = 1'b0;
    tx_bit = 1'b0;
    bit_strb = 1'b0;
    hbit_strb = 1'b0;
    repeat (10) @(negedge ucpd_clk);
    ic_rst_n = 1'b1;
    @(negedge ucpd_clk);
    // outputs right after reset
    assert (!receive_en) else begin
      err_val++;
      $display("ERR receive_en: got 0x%0h exp 0x0 after reset", receive_en);
    end
    assert (!locked) else begin
      err_val++;
      $display("ERR locked: got 0x%0h exp 0x0 after reset", locked);
    end
    assert (!rx_bit_vld) else begin
      err_val++;
      $display("ERR rx_bit_vld: got 0x%0h exp 0x0 after reset", rx_bit_vld);
    end
    assert (!cc_out) else begin
      err_val++;
      $display("ERR cc_out: got 0x%0h exp 0x0 after reset", cc_out);
    end
    assert (ui_thresh == '0) else begin
      err_val++;
      $display("ERR ui_thresh: got 0x%0h exp 0x0 after reset", ui_thresh);
    end
    for (r = 0; r < NUM_ROWS && !hung; r++) begin
      run_row(r);
    end
    if (!hung) begin
      check_encoder();
    end
    total = err_val + err_other + mon_err_val + mon_err_other;
    $display("error summary: %0d value errors, %0d other errors",
             err_val + mon_err_val, err_other + mon_err_other);
    if (total == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== sources.f ====
ucpd_pkg.sv
ucpd_cc_filter.sv
ucpd_ui_trainer.sv
ucpd_bmc_decoder.sv
ucpd_bmc_encoder.sv
ucpd_bmc_phy.sv
tb_ucpd_bmc_phy.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the BMC PHY testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_ucpd_bmc_phy -f sources.f -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1
cat sim.log

if grep -q "FAIL: see errors above" sim.log; then
  echo "simulation reported a failure"
  exit 1
fi
if ! grep -q "PASS: all tests" sim.log; then
  echo "simulation ended without a result"
  exit 1
fi
echo "simulation finished cleanly"
